/* hdl/burst_adaptor.sv */
`default_nettype none

module burst_adaptor (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire mem_types_pkg::addr_t addr_i,
    input  wire logic                 read_i,
    input  wire logic                 write_i,
    input  wire mem_types_pkg::line_t line_i,
    output mem_types_pkg::line_t      line_o,
    output logic                      resp_o,
    output mem_types_pkg::addr_t      addr_o,
    output logic                      read_o,
    output logic                      write_o,
    output mem_types_pkg::beat_t      burst_o,
    input  wire mem_types_pkg::beat_t burst_i,
    input  wire logic                 resp_i
);
    import mem_types_pkg::*;

    localparam logic [1:0] LAST_BEAT = 2'(BEATS_PER_LINE - 1);

    burst_state_e state_q;
    logic [1:0]   cnt_q;    // current beat
    line_t        line_q;   // gathered read line

    assign addr_o  = addr_i;                                    // line address held
    assign read_o  = (state_q == READ_BEATS);
    assign write_o = (state_q == WRITE_BEATS);
    assign burst_o = line_i[cnt_q * $bits(beat_t) +: $bits(beat_t)];  // beat 0 low
    assign line_o  = line_q;
    assign resp_o  = (state_q == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            cnt_q   <= 2'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= 2'd0;
                    if (read_i) begin
                        state_q <= READ_BEATS;
                    end else if (write_i) begin
                        state_q <= WRITE_BEATS;
                    end
                end
                READ_BEATS, WRITE_BEATS: begin
                    if (resp_i) begin
                        cnt_q <= cnt_q + 2'd1;                  // wraps to 0 after last
                        if (cnt_q == LAST_BEAT) begin
                            state_q <= DONE;
                        end
                    end
                end
                DONE:    state_q <= IDLE;                       // one-cycle resp
                default: state_q <= IDLE;
            endcase
        end
    end

    // beat capture, payload only
    always_ff @(posedge clk) begin
        if ((state_q == READ_BEATS) && resp_i) begin
            line_q[cnt_q * $bits(beat_t) +: $bits(beat_t)] <= burst_i;
        end
    end

    // line resp comes exactly one cycle after the fourth beat
    assert property (@(posedge clk) disable iff (rst)
        resp_o |-> $past(resp_i) && ($past(cnt_q) == LAST_BEAT))
        else $error("burst_adaptor: line resp without four beats");

endmodule

`default_nettype wire

/* hdl/line_cache.sv */
`default_nettype none

module line_cache #(
    parameter int NUM_SETS = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_types_pkg::addr_t  mem_addr_i,
    input  wire logic                  mem_read_i,
    input  wire logic                  mem_write_i,
    input  wire mem_types_pkg::word_t  mem_wdata_i,
    input  wire mem_types_pkg::wmask_t mem_wmask_i,
    output mem_types_pkg::word_t       mem_rdata_o,
    output logic                       mem_resp_o,
    output mem_types_pkg::addr_t       pmem_addr_o,
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output mem_types_pkg::line_t       pmem_wdata_o,
    input  wire mem_types_pkg::line_t  pmem_rdata_i,
    input  wire logic                  pmem_resp_i
);
    import mem_types_pkg::*;

    localparam int INDEX_BITS    = $clog2(NUM_SETS);
    localparam int TAG_BITS      = 32 - OFFSET_BITS - INDEX_BITS;
    localparam int WORD_SEL_BITS = OFFSET_BITS - 2;   // word within line
    localparam int LINE_BYTES    = 2 ** OFFSET_BITS;

    logic [TAG_BITS-1:0]      tag_q [NUM_SETS];   // no reset, valid_q guards
    line_t                    data_q [NUM_SETS];
    logic [NUM_SETS-1:0]      valid_q;
    logic [NUM_SETS-1:0]      dirty_q;

    cache_state_e             state_q;
    logic                     resp_q;             // hit answer, one cycle late

    logic [INDEX_BITS-1:0]    index;
    logic [TAG_BITS-1:0]      req_tag;
    logic [WORD_SEL_BITS-1:0] word_sel;
    logic                     mem_req;
    logic                     hit;
    logic                     hit_write;
    logic [LINE_BYTES-1:0]    line_wmask;         // byte mask in line position
    line_t                    line_wdata;         // word copied to every lane
    line_t                    merged_line;

    assign index    = mem_addr_i[OFFSET_BITS +: INDEX_BITS];
    assign req_tag  = mem_addr_i[31 -: TAG_BITS];
    assign word_sel = mem_addr_i[2 +: WORD_SEL_BITS];
    assign mem_req  = mem_read_i | mem_write_i;
    assign hit      = valid_q[index] && (tag_q[index] == req_tag);
    // new request only, not the resp cycle of the last one
    assign hit_write = (state_q == IDLE_HIT) && mem_write_i && hit && !resp_q;

    // lane steering, replaces the separate bus adapter
    assign mem_rdata_o = data_q[index][{word_sel, 5'b00000} +: 32];
    assign mem_resp_o  = resp_q;

    always_comb begin
        line_wmask  = {{(LINE_BYTES-4){1'b0}}, mem_wmask_i} << {word_sel, 2'b00};
        line_wdata  = {(LINE_BYTES/4){mem_wdata_i}};
        merged_line = data_q[index];
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (line_wmask[b]) begin
                merged_line[b*8 +: 8] = line_wdata[b*8 +: 8];  // take cpu byte
            end
        end
    end

    // line port, driven straight from state
    assign pmem_read_o  = (state_q == FILL);
    assign pmem_write_o = (state_q == WRITEBACK);
    assign pmem_wdata_o = data_q[index];                       // victim line
    assign pmem_addr_o  = (state_q == WRITEBACK)
                        ? {tag_q[index], index, {OFFSET_BITS{1'b0}}}  // victim's home
                        : {req_tag, index, {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE_HIT;
            resp_q  <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            resp_q <= 1'b0;                                     // pulse
            case (state_q)
                IDLE_HIT: begin
                    if (mem_req && !resp_q) begin
                        if (hit) begin
                            resp_q <= 1'b1;
                            if (mem_write_i) begin
                                dirty_q[index] <= 1'b1;
                            end
                        end else if (valid_q[index] && dirty_q[index]) begin
                            state_q <= WRITEBACK;
                        end else begin
                            state_q <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (pmem_resp_i) begin
                        state_q <= FILL;                        // victim is safe
                    end
                end
                FILL: begin
                    if (pmem_resp_i) begin
                        valid_q[index] <= 1'b1;
                        dirty_q[index] <= 1'b0;
                        state_q        <= IDLE_HIT;             // retry hits next
                    end
                end
                default: state_q <= IDLE_HIT;
            endcase
        end
    end

    // arrays, written on fill or write hit
    always_ff @(posedge clk) begin
        if ((state_q == FILL) && pmem_resp_i) begin
            data_q[index] <= pmem_rdata_i;
            tag_q[index]  <= req_tag;
        end else if (hit_write) begin
            data_q[index] <= merged_line;
        end
    end

    // requester never reads and writes at once
    assert property (@(posedge clk) disable iff (rst)
        !(mem_read_i && mem_write_i))
        else $error("line_cache: read and write high together");

    // a miss only answers after it is back in lookup
    assert property (@(posedge clk) disable iff (rst)
        $rose(mem_resp_o) |-> (state_q == IDLE_HIT) && ($past(state_q) == IDLE_HIT))
        else $error("line_cache: resp raised during writeback or fill");

endmodule

`default_nettype wire

/* hdl/mem_subsystem.sv */
`default_nettype none

module mem_subsystem #(
    parameter int NUM_SETS = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire mem_types_pkg::addr_t  fetch_addr_i,
    input  wire logic                  fetch_read_i,
    input  wire logic                  fetch_write_i,
    input  wire mem_types_pkg::word_t  fetch_wdata_i,
    input  wire mem_types_pkg::wmask_t fetch_wmask_i,
    output mem_types_pkg::word_t       fetch_rdata_o,
    output logic                       fetch_resp_o,
    input  wire mem_types_pkg::addr_t  data_addr_i,
    input  wire logic                  data_read_i,
    input  wire logic                  data_write_i,
    input  wire mem_types_pkg::word_t  data_wdata_i,
    input  wire mem_types_pkg::wmask_t data_wmask_i,
    output mem_types_pkg::word_t       data_rdata_o,
    output logic                       data_resp_o,
    output mem_types_pkg::addr_t       bmem_addr_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output mem_types_pkg::beat_t       bmem_wdata_o,
    input  wire mem_types_pkg::beat_t  bmem_rdata_i,
    input  wire logic                  bmem_resp_i
);
    import mem_types_pkg::*;

    addr_t ipmem_addr;   // fetch cache <-> arbiter
    logic  ipmem_read;
    logic  ipmem_write;
    line_t ipmem_wdata;
    line_t ipmem_rdata;
    logic  ipmem_resp;
    addr_t dpmem_addr;   // data cache <-> arbiter
    logic  dpmem_read;
    logic  dpmem_write;
    line_t dpmem_wdata;
    line_t dpmem_rdata;
    logic  dpmem_resp;
    addr_t pmem_addr;    // arbiter <-> adaptor
    logic  pmem_read;
    logic  pmem_write;
    line_t pmem_wdata;
    line_t pmem_rdata;
    logic  pmem_resp;

    // fetch side also takes writes, for the loader
    line_cache #(.NUM_SETS(NUM_SETS)) fetch_cache (
        .clk, .rst,
        .mem_addr_i  (fetch_addr_i),  .mem_read_i   (fetch_read_i),
        .mem_write_i (fetch_write_i), .mem_wdata_i  (fetch_wdata_i),
        .mem_wmask_i (fetch_wmask_i), .mem_rdata_o  (fetch_rdata_o),
        .mem_resp_o  (fetch_resp_o),  .pmem_addr_o  (ipmem_addr),
        .pmem_read_o (ipmem_read),    .pmem_write_o (ipmem_write),
        .pmem_wdata_o(ipmem_wdata),   .pmem_rdata_i (ipmem_rdata),
        .pmem_resp_i (ipmem_resp)
    );

    line_cache #(.NUM_SETS(NUM_SETS)) data_cache (
        .clk, .rst,
        .mem_addr_i  (data_addr_i),   .mem_read_i   (data_read_i),
        .mem_write_i (data_write_i),  .mem_wdata_i  (data_wdata_i),
        .mem_wmask_i (data_wmask_i),  .mem_rdata_o  (data_rdata_o),
        .mem_resp_o  (data_resp_o),   .pmem_addr_o  (dpmem_addr),
        .pmem_read_o (dpmem_read),    .pmem_write_o (dpmem_write),
        .pmem_wdata_o(dpmem_wdata),   .pmem_rdata_i (dpmem_rdata),
        .pmem_resp_i (dpmem_resp)
    );

    port_arbiter arbiter (
        .clk, .rst,
        .ipmem_addr_i  (ipmem_addr),  .ipmem_read_i (ipmem_read),
        .ipmem_write_i (ipmem_write), .ipmem_wdata_i(ipmem_wdata),
        .ipmem_rdata_o (ipmem_rdata), .ipmem_resp_o (ipmem_resp),
        .dpmem_addr_i  (dpmem_addr),  .dpmem_read_i (dpmem_read),
        .dpmem_write_i (dpmem_write), .dpmem_wdata_i(dpmem_wdata),
        .dpmem_rdata_o (dpmem_rdata), .dpmem_resp_o (dpmem_resp),
        .pmem_addr_o   (pmem_addr),   .pmem_read_o  (pmem_read),
        .pmem_write_o  (pmem_write),  .pmem_wdata_o (pmem_wdata),
        .pmem_rdata_i  (pmem_rdata),  .pmem_resp_i  (pmem_resp)
    );

    burst_adaptor adaptor (
        .clk, .rst,
        .addr_i (pmem_addr),   .read_i  (pmem_read),
        .write_i(pmem_write),  .line_i  (pmem_wdata),
        .line_o (pmem_rdata),  .resp_o  (pmem_resp),
        .addr_o (bmem_addr_o), .read_o  (bmem_read_o),
        .write_o(bmem_write_o), .burst_o (bmem_wdata_o),
        .burst_i(bmem_rdata_i), .resp_i  (bmem_resp_i)
    );

endmodule

`default_nettype wire

/* hdl/mem_types_pkg.sv */
`default_nettype none

package mem_types_pkg;

    typedef logic [31:0]  addr_t;   // byte address
    typedef logic [31:0]  word_t;   // cpu data word
    typedef logic [3:0]   wmask_t;  // byte enables of one word
    typedef logic [255:0] line_t;   // one cache line
    typedef logic [63:0]  beat_t;   // one burst beat

    localparam int BEATS_PER_LINE = 4;  // 4 x 64 = 256
    localparam int OFFSET_BITS    = 5;  // 32 bytes per line

    // cache controller
    typedef enum logic [1:0] {
        IDLE_HIT,   // lookup, hit answers next cycle
        WRITEBACK,  // dirty victim out
        FILL        // new line in
    } cache_state_e;

    // shared line port owner
    typedef enum logic [1:0] {
        FREE,
        GRANT_FETCH,
        GRANT_DATA
    } arb_state_e;

    // line <-> beats
    typedef enum logic [1:0] {
        IDLE,
        READ_BEATS,
        WRITE_BEATS,
        DONE        // one-cycle line resp
    } burst_state_e;

endpackage

`default_nettype wire

/* hdl/port_arbiter.sv */
`default_nettype none

module port_arbiter (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire mem_types_pkg::addr_t ipmem_addr_i,
    input  wire logic                 ipmem_read_i,
    input  wire logic                 ipmem_write_i,
    input  wire mem_types_pkg::line_t ipmem_wdata_i,
    output mem_types_pkg::line_t      ipmem_rdata_o,
    output logic                      ipmem_resp_o,
    input  wire mem_types_pkg::addr_t dpmem_addr_i,
    input  wire logic                 dpmem_read_i,
    input  wire logic                 dpmem_write_i,
    input  wire mem_types_pkg::line_t dpmem_wdata_i,
    output mem_types_pkg::line_t      dpmem_rdata_o,
    output logic                      dpmem_resp_o,
    output mem_types_pkg::addr_t      pmem_addr_o,
    output logic                      pmem_read_o,
    output logic                      pmem_write_o,
    output mem_types_pkg::line_t      pmem_wdata_o,
    input  wire mem_types_pkg::line_t pmem_rdata_i,
    input  wire logic                 pmem_resp_i
);
    import mem_types_pkg::*;

    arb_state_e state_q;
    logic       ireq;
    logic       dreq;
    logic       sel_data;   // data cache owns the port this cycle

    assign ireq = ipmem_read_i | ipmem_write_i;
    assign dreq = dpmem_read_i | dpmem_write_i;

    always_comb begin
        case (state_q)
            GRANT_DATA:  sel_data = 1'b1;
            GRANT_FETCH: sel_data = 1'b0;
            default:     sel_data = dreq;   // free, data wins a tie
        endcase
    end

    assign pmem_addr_o  = sel_data ? dpmem_addr_i  : ipmem_addr_i;
    assign pmem_read_o  = sel_data ? dpmem_read_i  : ipmem_read_i;
    assign pmem_write_o = sel_data ? dpmem_write_i : ipmem_write_i;
    assign pmem_wdata_o = sel_data ? dpmem_wdata_i : ipmem_wdata_i;

    assign ipmem_rdata_o = pmem_rdata_i;                // both see the line
    assign dpmem_rdata_o = pmem_rdata_i;
    assign ipmem_resp_o  = pmem_resp_i && !sel_data;    // only the owner
    assign dpmem_resp_o  = pmem_resp_i && sel_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FREE;
        end else begin
            case (state_q)
                FREE: begin
                    if (dreq) begin
                        state_q <= GRANT_DATA;
                    end else if (ireq) begin
                        state_q <= GRANT_FETCH;
                    end
                end
                GRANT_FETCH, GRANT_DATA: begin
                    if (pmem_resp_i) begin
                        state_q <= FREE;                // release after resp
                    end
                end
                default: state_q <= FREE;
            endcase
        end
    end

    // a line resp lands only on the cache that holds the grant
    assert property (@(posedge clk) disable iff (rst)
        (!ipmem_resp_o || (state_q == GRANT_FETCH))
        && (!dpmem_resp_o || (state_q == GRANT_DATA)))
        else $error("port_arbiter: resp outside a single grant");

endmodule

`default_nettype wire

/* mem_subsystem.f */
hdl/mem_types_pkg.sv
hdl/line_cache.sv
hdl/port_arbiter.sv
hdl/burst_adaptor.sv
hdl/mem_subsystem.sv
verification/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module mem_subsystem_tb \
    -f mem_subsystem.f \
    && ./obj_dir/Vmem_subsystem_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "RESULT: build or run error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }

/* verification/mem_subsystem_tb.sv */
`default_nettype none

module mem_subsystem_tb;
    import mem_types_pkg::*;

    localparam int NUM_SETS      = 16;   // trace addresses assume 16 sets of 32 bytes
    localparam int MAX_OPS       = 64;
    localparam int FIELDS        = 6;    // port kind addr wdata mask expected
    localparam int CYCLES_PER_OP = 200;

    logic   clk;
    logic   rst;
    addr_t  fetch_addr;
    logic   fetch_read;
    logic   fetch_write;
    word_t  fetch_wdata;
    wmask_t fetch_wmask;
    word_t  fetch_rdata;
    logic   fetch_resp;
    addr_t  data_addr;
    logic   data_read;
    logic   data_write;
    word_t  data_wdata;
    wmask_t data_wmask;
    word_t  data_rdata;
    logic   data_resp;
    addr_t  bmem_addr;
    logic   bmem_read;
    logic   bmem_write;
    beat_t  bmem_wdata;
    beat_t  bmem_rdata;
    logic   bmem_resp;

    logic [31:0] trace_mem [MAX_OPS*FIELDS];  // flat records from the trace file
    word_t       mem [addr_t];                // written words only, rest is ~addr
    int          num_ops;
    int          cycle_count;
    int          cycle_limit;
    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          fetch_op;                    // record pending on fetch, -1 none
    int          data_op;

    mem_subsystem #(.NUM_SETS(NUM_SETS)) DUT (
        .clk, .rst,
        .fetch_addr_i (fetch_addr),  .fetch_read_i (fetch_read),
        .fetch_write_i(fetch_write), .fetch_wdata_i(fetch_wdata),
        .fetch_wmask_i(fetch_wmask), .fetch_rdata_o(fetch_rdata),
        .fetch_resp_o (fetch_resp),
        .data_addr_i  (data_addr),   .data_read_i  (data_read),
        .data_write_i (data_write),  .data_wdata_i (data_wdata),
        .data_wmask_i (data_wmask),  .data_rdata_o (data_rdata),
        .data_resp_o  (data_resp),
        .bmem_addr_o  (bmem_addr),   .bmem_read_o  (bmem_read),
        .bmem_write_o (bmem_write),  .bmem_wdata_o (bmem_wdata),
        .bmem_rdata_i (bmem_rdata),  .bmem_resp_i  (bmem_resp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 unit period

    // watchdog, limit follows the trace length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: no response within %0d cycles, run stopped", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic word_t mem_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;                                  // untouched word
    endfunction

    function automatic logic [31:0] field(input int op, input int k);
        return trace_mem[op*FIELDS + k];
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("pass  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    // burst memory, random gap before every beat
    initial begin : burst_memory
        int unsigned gap;
        int          beat;
        addr_t       at;
        void'($urandom(32'h8a29_ed94));
        bmem_rdata = '0;
        bmem_resp  = 1'b0;
        beat       = 0;
        forever begin
            @(negedge clk);
            bmem_resp = 1'b0;
            if (!rst && (bmem_read || bmem_write)) begin
                gap = $urandom_range(3, 0);
                repeat (gap) @(negedge clk);
                at = bmem_addr + addr_t'(8 * beat);    // beat 0 is the low 64 bits
                if (bmem_write) begin
                    mem[at]     = bmem_wdata[31:0];    // beat accepted here
                    mem[at + 4] = bmem_wdata[63:32];
                end
                bmem_rdata = {mem_word(at + 4), mem_word(at)};
                bmem_resp  = 1'b1;
                beat       = (beat + 1) % BEATS_PER_LINE;
            end
        end
    end

    task automatic drive_op(input int op);
        logic is_write;
        is_write = (field(op, 1) == 32'd1);
        if (field(op, 0) == 32'd0) begin
            fetch_addr  = field(op, 2);
            fetch_wdata = field(op, 3);
            fetch_wmask = wmask_t'(field(op, 4));
            fetch_read  = !is_write;
            fetch_write = is_write;
            fetch_op    = op;
        end else begin
            data_addr  = field(op, 2);
            data_wdata = field(op, 3);
            data_wmask = wmask_t'(field(op, 4));
            data_read  = !is_write;
            data_write = is_write;
            data_op    = op;
        end
    endtask

    task automatic finish_op(input int op, input word_t rdata);
        int    errors_before;
        string name;
        errors_before = error_count;
        name = $sformatf("record %0d %s %s at %h", op,
                         (field(op, 0) == 32'd0) ? "fetch" : "data",
                         (field(op, 1) == 32'd1) ? "write" : "read", field(op, 2));
        if (field(op, 1) != 32'd1) begin
            check_value(rdata, field(op, 5), name);
        end
        report_test(name, errors_before);
    endtask

    // rdata is sampled on the falling edge of the resp cycle
    task automatic await_responses();
        while (fetch_op >= 0 || data_op >= 0) begin
            @(negedge clk);
            if (fetch_op >= 0 && fetch_resp) begin
                finish_op(fetch_op, fetch_rdata);
                fetch_read  = 1'b0;
                fetch_write = 1'b0;
                fetch_op    = -1;
            end
            if (data_op >= 0 && data_resp) begin
                finish_op(data_op, data_rdata);
                data_read  = 1'b0;
                data_write = 1'b0;
                data_op    = -1;
            end
        end
    endtask

    initial begin : main
        int op;
        int i;
        int errors_before;
        rst         = 1'b1;
        fetch_addr  = '0;
        fetch_read  = 1'b0;
        fetch_write = 1'b0;
        fetch_wdata = '0;
        fetch_wmask = '0;
        data_addr   = '0;
        data_read   = 1'b0;
        data_write  = 1'b0;
        data_wdata  = '0;
        data_wmask  = '0;
        fetch_op    = -1;
        data_op     = -1;
        for (i = 0; i < MAX_OPS*FIELDS; i++) begin
            trace_mem[i] = '1;                        // all ones marks the end
        end
        $readmemh("verification/mem_trace.txt", trace_mem);
        num_ops = 0;
        while (num_ops < MAX_OPS && field(num_ops, 0) != 32'hffff_ffff) begin
            num_ops++;
        end
        cycle_limit = CYCLES_PER_OP * num_ops + 40;   // margin for reset

        errors_before = error_count;
        repeat (8) begin
            @(negedge clk);
            check_value({28'd0, fetch_resp, data_resp, bmem_read, bmem_write}, 32'd0,
                        "resp or bmem request high during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_value({28'd0, fetch_resp, data_resp, bmem_read, bmem_write}, 32'd0,
                    "resp or bmem request high after reset");
        report_test("reset state", errors_before);

        if (num_ops == 0) begin
            tests_failed++;
            $display("the trace file gave no records to run");
        end
        op = 0;
        while (op < num_ops) begin
            drive_op(op);
            if (field(op, 1) == 32'd2 && op + 1 < num_ops) begin
                drive_op(op + 1);                     // both ports in the same cycle
                op += 2;
            end else begin
                op += 1;
            end
            await_responses();
        end

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_trace.txt */
// port (0 fetch, 1 data)  kind (0 read, 1 write, 2 read issued with the next record)
// addr  wdata  mask  expected_rdata, all hex; expected is ignored for writes
1 0 00010040 00000000 0 fffeffbf
1 0 0001005c 00000000 0 fffeffa3
0 0 00000100 00000000 0 fffffeff
0 0 00000108 00000000 0 fffffef7
1 1 00010044 a5a5a5a5 5 00000000
1 0 00010044 00000000 0 ffa5ffa5
1 1 00010200 12345678 f 00000000
1 0 00010400 00000000 0 fffefbff
1 0 00010200 00000000 0 12345678
1 0 00010204 00000000 0 fffefdfb
0 2 00000300 00000000 0 fffffcff
1 0 00010300 00000000 0 fffefcff
0 2 00000520 00000000 0 fffffadf
1 0 00010640 00000000 0 fffef9bf
1 0 00010044 00000000 0 ffa5ffa5
0 1 00000800 00000013 f 00000000
0 1 00000804 0000beef 3 00000000
0 0 00000800 00000000 0 00000013
0 0 00000804 00000000 0 ffffbeef
0 0 00000000 00000000 0 ffffffff
0 0 00000804 00000000 0 ffffbeef
